/* src/mandelPkg.sv */
`default_nettype none

package mandelPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int coordW  = 36;           // 4 integer bits + 32 fraction bits
  localparam int addrW   = 19;           // Enough for 640 x 480
  localparam int screenXW = 10;
  localparam int screenYW = 9;
  localparam int colorW  = 3;
  localparam int iterW   = 7;
  localparam int zoomW   = 5;

  typedef logic signed [coordW-1:0]   coordT;   // Plane coordinate
  typedef logic        [addrW-1:0]    pixAddrT; // Column + row * width
  typedef logic        [screenXW-1:0] screenXT; // Pixel column
  typedef logic        [screenYW-1:0] screenYT; // Pixel row
  typedef logic        [colorW-1:0]   colorT;
  typedef logic        [iterW-1:0]    iterT;
  typedef logic        [zoomW-1:0]    zoomT;    // Right shift of the base step

  ////////////////////////////////////////
  // Fixed-point constants
  ////////////////////////////////////////
  localparam int fracBits = 32;

  // 3/640 * 2^32, truncated
  localparam coordT stepBase = 36'sd20132659;

  // 4.0 in plane format, escape radius squared
  localparam coordT escapeLimit = 36'sh4_0000_0000;

  localparam iterT maxIter = 7'd100;       // Points surviving this are in the set

  ////////////////////////////////////////
  // Processor pool
  ////////////////////////////////////////
  localparam int numProcs = 4;
  localparam int procIdxW = $clog2(numProcs);

  typedef logic [procIdxW-1:0] procIdxT;   // Arbiter pointer

  // One point to evaluate, 91 bits
  typedef struct packed {
    coordT   coordX;  // Real part of c
    coordT   coordY;  // Imaginary part of c
    pixAddrT pixAddr; // Destination in frame buffer
  } coordJobT;

  // One finished pixel, 22 bits
  typedef struct packed {
    pixAddrT pixAddr;
    colorT   color;
  } pixResultT;

endpackage

`default_nettype wire

/* src/coordGenerator.sv */
`timescale 1ns/1ps
`default_nettype none

module coordGenerator
  import mandelPkg::*;
#(
  parameter int frameWidth  = 640,
  parameter int frameHeight = 480
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     draw,        // Start of frame strobe
  input  zoomT     zoom,
  input  coordT    upperLeftX,
  input  coordT    upperLeftY,
  input  logic     jobRdy,      // From load balancer
  output logic     jobVal,
  output coordJobT job
);

  screenXT col;
  screenYT row;
  coordT   step;    // Distance between neighbor pixels
  coordT   startX;  // Row restart value for real part
  coordT   curX;
  coordT   curY;
  pixAddrT addr;    // Running linear address

  logic xfer;
  logic lastCol;
  logic lastPix;

  assign xfer    = jobVal && jobRdy;
  assign lastCol = (col == screenXT'(frameWidth - 1));
  assign lastPix = lastCol && (row == screenYT'(frameHeight - 1));

  assign job = '{coordX: curX, coordY: curY, pixAddr: addr};

  // Scan control
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      jobVal <= 1'b0;
      col    <= '0;
      row    <= '0;
    end
    else if (!jobVal && draw) // Draw ignored mid-frame
    begin
      jobVal <= 1'b1;
      col    <= '0;
      row    <= '0;
    end
    else if (xfer)
    begin
      if (lastPix)
        jobVal <= 1'b0;       // Frame done
      else if (lastCol)
      begin
        col <= '0;
        row <= row + 1'b1;
      end
      else
        col <= col + 1'b1;
    end
  end

  // Coordinate stepping, adds instead of multiplies
  always_ff @(posedge clk)
  begin
    if (!jobVal && draw)
    begin
      step   <= stepBase >> zoom;
      startX <= upperLeftX;
      curX   <= upperLeftX;
      curY   <= upperLeftY;
      addr   <= '0;
    end
    else if (xfer)
    begin
      addr <= addr + 1'b1;    // Row-major, so address just counts
      if (lastCol)
      begin
        curX <= startX;       // Back to left edge
        curY <= curY + step;
      end
      else
        curX <= curX + step;
    end
  end

endmodule

`default_nettype wire

/* src/loadBalancer.sv */
`timescale 1ns/1ps
`default_nettype none

module loadBalancer
  import mandelPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                jobVal,
  input  coordJobT            job,
  output logic                jobRdy,
  input  logic [numProcs-1:0] procRdy,   // Free processors
  output logic [numProcs-1:0] procStart, // One-hot dispatch
  output coordJobT            procJob    // Shared by all processors
);

  coordJobT            jobReg;
  logic                full;
  logic [numProcs-1:0] pick;   // Lowest free processor
  logic                dispatch;

  assign jobRdy   = !full;     // Accept only when empty
  assign procJob  = jobReg;
  assign dispatch = full && (|procRdy);
  assign procStart = full ? pick : '0;

  // Priority pick, index 0 wins
  always_comb
  begin
    pick = '0;
    for (int i = numProcs - 1; i >= 0; i--)
    begin
      if (procRdy[i])
        pick = '0;
      if (procRdy[i])
        pick[i] = 1'b1;        // Lower index overrides
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      full <= 1'b0;
    else if (dispatch)
      full <= 1'b0;            // Frees on start edge
    else if (jobVal && !full)
      full <= 1'b1;
  end

  // Job payload
  always_ff @(posedge clk)
  begin
    if (jobVal && !full)
      jobReg <= job;
  end

endmodule

`default_nettype wire

/* src/mandelProcessor.sv */
`timescale 1ns/1ps
`default_nettype none

module mandelProcessor
  import mandelPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,     // One-cycle dispatch from balancer
  input  coordJobT  jobIn,
  input  logic      stored,    // Arbiter took the result
  output logic      ready,
  output logic      resultVal,
  output pixResultT result
);

  typedef enum logic [1:0] {
    stIdle,
    stIterate,
    stHold
  } procStateT;

  procStateT state;
  coordJobT  job;      // Latched point
  coordT     zRe;
  coordT     zIm;
  iterT      iter;     // Updates done so far
  colorT     color;

  logic signed [2*coordW-1:0] reFull;
  logic signed [2*coordW-1:0] imFull;
  logic signed [2*coordW-1:0] crossFull;
  coordT                      reSq;
  coordT                      imSq;
  coordT                      crossSq;
  logic signed [coordW:0]     magSq;   // One extra bit so the sum cannot wrap
  logic                       escaped;
  logic                       lastIter;

  ////////////////////////////////////////
  // Squares, full product then >>> fracBits
  ////////////////////////////////////////
  assign reFull    = zRe * zRe;
  assign imFull    = zIm * zIm;
  assign crossFull = zRe * zIm;

  assign reSq    = reFull[fracBits +: coordW];     // Truncate to 36 bits
  assign imSq    = imFull[fracBits +: coordW];
  assign crossSq = crossFull[fracBits +: coordW];

  assign magSq    = (coordW + 1)'(reSq) + (coordW + 1)'(imSq);
  assign escaped  = magSq > (coordW + 1)'(escapeLimit);
  assign lastIter = (iter == maxIter - 1'b1);    // This update is the 100th

  assign result = '{pixAddr: job.pixAddr, color: color};

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= stIdle;
      ready     <= 1'b1;
      resultVal <= 1'b0;
      iter      <= '0;
    end
    else
    begin
      case (state)
        stIdle:
          if (start)
          begin
            state <= stIterate;
            ready <= 1'b0;         // Drops the cycle after start
            iter  <= '0;
          end
        stIterate:
          if (escaped || lastIter)
          begin
            state     <= stHold;
            resultVal <= 1'b1;
          end
          else
            iter <= iter + 1'b1;
        stHold:
          if (stored)
          begin
            state     <= stIdle;
            resultVal <= 1'b0;
            ready     <= 1'b1;     // Back one cycle after stored
          end
        default:
          state <= stIdle;
      endcase
    end
  end

  // Datapath, one update per cycle
  always_ff @(posedge clk)
  begin
    if (state == stIdle && start)
    begin
      job <= jobIn;
      zRe <= '0;                   // z starts at origin
      zIm <= '0;
    end
    else if (state == stIterate)
    begin
      if (escaped)
        color <= colorT'((iter % 7) + 1);  // Escaped, cycle through 1..7
      else if (lastIter)
        color <= '0;                       // In the set
      else
      begin
        zRe <= reSq - imSq + job.coordX;
        zIm <= crossSq + crossSq + job.coordY;
      end
    end
  end

endmodule

`default_nettype wire

/* src/proc2memArb.sv */
`timescale 1ns/1ps
`default_nettype none

module proc2memArb
  import mandelPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numProcs-1:0] resultVal,          // Pending results
  input  pixResultT           results [numProcs],
  output logic [numProcs-1:0] stored,             // One-hot grant
  output logic                pixWren,
  output pixResultT           pixWrite
);

  procIdxT             lastGrant;   // Search starts just past this
  procIdxT             grantIdx;
  logic                anyGrant;
  logic [numProcs-1:0] grant;

  ////////////////////////////////////////
  // Round-robin pick
  ////////////////////////////////////////
  always_comb
  begin
    int cand;
    grant    = '0;
    grantIdx = lastGrant;
    anyGrant = 1'b0;
    for (int k = 1; k <= numProcs; k++)
    begin
      cand = (int'(lastGrant) + k) % numProcs;   // Wrap around the pool
      if (!anyGrant && resultVal[cand])
      begin
        anyGrant    = 1'b1;
        grantIdx    = procIdxT'(cand);
        grant[cand] = 1'b1;
      end
    end
  end

  assign stored = grant;   // Processor frees on this edge

  // Pointer and write strobe
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lastGrant <= procIdxT'(numProcs - 1);  // First search begins at 0
      pixWren   <= 1'b0;
    end
    else
    begin
      pixWren <= anyGrant;
      if (anyGrant)
        lastGrant <= grantIdx;
    end
  end

  // Write payload, one cycle behind the grant
  always_ff @(posedge clk)
  begin
    if (anyGrant)
      pixWrite <= results[grantIdx];
  end

endmodule

`default_nettype wire

/* src/mandelTop.sv */
`timescale 1ns/1ps
`default_nettype none

module mandelTop
  import mandelPkg::*;
#(
  parameter int frameWidth  = 640,
  parameter int frameHeight = 480
)
(
  input  logic      clk,
  input  logic      rst,
  input  logic      draw,        // Start one frame
  input  zoomT      zoom,
  input  coordT     upperLeftX,
  input  coordT     upperLeftY,
  output logic      pixWren,     // Frame-buffer write strobe
  output pixResultT pixWrite
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////
  logic                jobVal;
  logic                jobRdy;
  coordJobT            job;

  logic [numProcs-1:0] procRdy;
  logic [numProcs-1:0] procStart;
  coordJobT            procJob;    // Broadcast to all processors

  logic [numProcs-1:0] resultVal;
  pixResultT           results [numProcs];
  logic [numProcs-1:0] stored;

  // Pixel scan
  coordGenerator #(
    .frameWidth (frameWidth),
    .frameHeight(frameHeight)
  ) u_coordGenerator (
    .clk       (clk),
    .rst       (rst),
    .draw      (draw),
    .zoom      (zoom),
    .upperLeftX(upperLeftX),
    .upperLeftY(upperLeftY),
    .jobRdy    (jobRdy),
    .jobVal    (jobVal),
    .job       (job)
  );

  loadBalancer u_loadBalancer (
    .clk      (clk),
    .rst      (rst),
    .jobVal   (jobVal),
    .job      (job),
    .jobRdy   (jobRdy),
    .procRdy  (procRdy),
    .procStart(procStart),
    .procJob  (procJob)
  );

  // Processor pool
  for (genvar g = 0; g < numProcs; g++)
  begin : genProc
    mandelProcessor u_mandelProcessor (
      .clk      (clk),
      .rst      (rst),
      .start    (procStart[g]),
      .jobIn    (procJob),
      .stored   (stored[g]),
      .ready    (procRdy[g]),
      .resultVal(resultVal[g]),
      .result   (results[g])
    );
  end

  proc2memArb u_proc2memArb (
    .clk      (clk),
    .rst      (rst),
    .resultVal(resultVal),
    .results  (results),
    .stored   (stored),
    .pixWren  (pixWren),
    .pixWrite (pixWrite)
  );

endmodule

`default_nettype wire

/* verification/mandelModel.svh */
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

////////////////////////////////////////
// Reference model, fixed-point Mandelbrot
////////////////////////////////////////

// Plane coordinate of one pixel along an axis
function automatic coordT pixelCoord(input coordT corner, input int pos, input zoomT z);
  coordT step;
  step = stepBase >>> z;              // Narrower step per zoom level
  return corner + coordT'(pos) * step;
endfunction

// Square of a coordinate, full product then arithmetic shift
function automatic coordT fixedMul(input coordT a, input coordT b);
  logic signed [2*coordW-1:0] full;
  full = a * b;
  return coordT'(full >>> fracBits);  // Truncated to 36 bits
endfunction

// Escape-time color for one point
function automatic colorT modelColor(input coordT cx, input coordT cy);
  coordT zr;
  coordT zi;
  coordT reSq;
  coordT imSq;
  coordT crSq;
  int    n;
  zr = '0;
  zi = '0;
  for (n = 0; n < int'(maxIter); n++)
  begin
    reSq = fixedMul(zr, zr);
    imSq = fixedMul(zi, zi);
    crSq = fixedMul(zr, zi);
    // Sum in 64 bits so it cannot wrap
    if (longint'(reSq) + longint'(imSq) > longint'(escapeLimit))
      return colorT'((n % 7) + 1);    // Escaped after n updates
    zr = reSq - imSq + cx;
    zi = 2 * crSq + cy;
  end
  return '0;                          // In the set
endfunction

`endif

/* verification/mandelTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mandelTb
  import mandelPkg::*;
();

  `include "mandelModel.svh"

  localparam int frameW      = 8;
  localparam int frameH      = 6;
  localparam int frameSize   = frameW * frameH;
  localparam int resetCycles = 8;
  localparam int numTests    = 5;
  localparam int cycleLimit  = numTests * frameSize * (int'(maxIter) + 8) + resetCycles;

  // Corners in plane format
  localparam coordT defX  = -36'sd8589934592;   // -2.0
  localparam coordT defY  = -36'sd4831838208;   // -1.125
  localparam coordT zoomX = -36'sd3221225472;   // -0.75 in the seahorse valley
  localparam coordT zoomY = 36'sd429496730;     // About 0.1
  localparam coordT insX  = -36'sd1073741824;   // -0.25 inside the main cardioid
  localparam coordT insY  = -36'sd536870912;    // -0.125

  logic      clk;
  logic      rst;
  logic      draw;
  zoomT      zoom;
  coordT     upperLeftX;
  coordT     upperLeftY;
  logic      pixWren;
  pixResultT pixWrite;

  // Scoreboard
  colorT   colorMem [frameSize];
  int      hits [frameSize];
  int      writesTotal;
  pixAddrT maxAddr;
  int      errors;
  int      cycles;

  mandelTop #(
    .frameWidth (frameW),
    .frameHeight(frameH)
  ) u_mandelTop (
    .clk       (clk),
    .rst       (rst),
    .draw      (draw),
    .zoom      (zoom),
    .upperLeftX(upperLeftX),
    .upperLeftY(upperLeftY),
    .pixWren   (pixWren),
    .pixWrite  (pixWrite)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Monitor and watchdog
  ////////////////////////////////////////
  always @(negedge clk)                 // Outputs settled by mid-cycle
  begin
    if (pixWren)
    begin
      writesTotal++;
      if (pixWrite.pixAddr < frameSize)
      begin
        colorMem[pixWrite.pixAddr] = pixWrite.color;
        hits[pixWrite.pixAddr]++;
        if (pixWrite.pixAddr > maxAddr)
          maxAddr = pixWrite.pixAddr;
      end
      else
      begin
        $display("Write to address %0d outside the frame", pixWrite.pixAddr);
        errors++;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycleLimit)
    begin
      $display("Timeout after %0d cycles, frame never completed", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic compareColor(input string name, input colorT exp, input colorT got);
    if (exp !== got)
    begin
      $display("ERR %s: expected 0x%h, got 0x%h", name, exp, got);
      errors++;
    end
  endtask

  task automatic compareAddr(input string name, input pixAddrT exp, input pixAddrT got);
    if (exp !== got)
    begin
      $display("ERR %s: expected 0x%h, got 0x%h", name, exp, got);
      errors++;
    end
  endtask

  task automatic compareCount(input string name, input int exp, input int got);
    if (exp !== got)
    begin
      $display("ERR %s: expected 0x%0h, got 0x%0h", name, exp, got);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic clearBoard();
    for (int i = 0; i < frameSize; i++)
    begin
      hits[i]     = 0;
      colorMem[i] = '0;
    end
    writesTotal = 0;
    maxAddr     = '0;
  endtask

  task automatic startFrame(input coordT ulX, input coordT ulY, input zoomT z);
    @(posedge clk);
    draw       <= 1'b1;                 // Corner and zoom sampled with draw
    zoom       <= z;
    upperLeftX <= ulX;
    upperLeftY <= ulY;
    @(posedge clk);
    draw <= 1'b0;
  endtask

  task automatic waitFrame();
    while (writesTotal < frameSize)
      @(posedge clk);
    repeat (20) @(posedge clk);         // Catch any extra writes
  endtask

  // Per-pixel count and color against the model
  task automatic checkColors(input coordT ulX, input coordT ulY, input zoomT z);
    int    idx;
    colorT exp;
    for (int y = 0; y < frameH; y++)
    begin
      for (int x = 0; x < frameW; x++)
      begin
        idx = x + y * frameW;
        exp = modelColor(pixelCoord(ulX, x, z), pixelCoord(ulY, y, z));
        compareCount($sformatf("write count[%0d]", idx), 1, hits[idx]);
        compareColor($sformatf("pixWrite.color[%0d]", idx), exp, colorMem[idx]);
      end
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic testDefaultView();
    clearBoard();
    startFrame(defX, defY, 5'd0);
    waitFrame();
    checkColors(defX, defY, 5'd0);
  endtask

  // Uses the scoreboard left by the default view
  task automatic testCoverage();
    compareCount("total writes", frameSize, writesTotal);
    compareAddr("highest pixWrite.pixAddr", pixAddrT'(frameSize - 1), maxAddr);
  endtask

  task automatic testZoomOffset();
    clearBoard();
    startFrame(zoomX, zoomY, 5'd3);
    waitFrame();
    checkColors(zoomX, zoomY, 5'd3);
  endtask

  task automatic testInterior();
    clearBoard();
    startFrame(insX, insY, 5'd4);
    waitFrame();
    for (int i = 0; i < frameSize; i++)
    begin
      compareCount($sformatf("write count[%0d]", i), 1, hits[i]);
      compareColor($sformatf("pixWrite.color[%0d]", i), '0, colorMem[i]);
    end
    compareCount("total writes", frameSize, writesTotal);
  endtask

  task automatic testResetMidFrame();
    clearBoard();
    startFrame(defX, defY, 5'd0);
    while (writesTotal < 10)
      @(posedge clk);
    rst <= 1'b1;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
    clearBoard();
    repeat (200) @(posedge clk);        // Pipeline must stay silent
    compareCount("writes after reset", 0, writesTotal);
    startFrame(defX, defY, 5'd0);
    waitFrame();
    checkColors(defX, defY, 5'd0);
    compareCount("total writes", frameSize, writesTotal);
  endtask

  initial
  begin
    rst        = 1'b1;
    draw       = 1'b0;
    zoom       = '0;
    upperLeftX = '0;
    upperLeftY = '0;
    errors     = 0;
    cycles     = 0;
    clearBoard();
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
    testDefaultView();
    testCoverage();
    testZoomOffset();
    testInterior();
    testResetMidFrame();
    $display("Summary: %0d errors in %0d cycles", errors, cycles);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
src/mandelPkg.sv
src/coordGenerator.sv
src/loadBalancer.sv
src/mandelProcessor.sv
src/proc2memArb.sv
src/mandelTop.sv
+incdir+verification
verification/mandelTb.sv
